/* design/lu_pkg.sv */
// Quadword geometry and load size codes for the alignment path; size codes 5 to 7 mean 16 bytes
package lu_pkg;

   // Byte lanes in one quadword read from the data cache
   localparam int QW_BYTES = 16;

   // Width of a byte offset and of a rotate amount within the quadword
   localparam int ROT_BITS = 4;

   // The endian stage picks straight or mirrored lanes
   localparam int ENDIAN_SEL_BITS = 2;

   // Coarse and fine rotate stages each take a four-way one-hot select
   localparam int ROT_SEL_BITS = 4;

   // Width of the load size code
   localparam int SIZE_BITS = 3;

   // Load size codes, log2 of the size in bytes
   localparam logic [SIZE_BITS-1:0] SZ_1  = 3'd0;
   localparam logic [SIZE_BITS-1:0] SZ_2  = 3'd1;
   localparam logic [SIZE_BITS-1:0] SZ_4  = 3'd2;
   localparam logic [SIZE_BITS-1:0] SZ_8  = 3'd3;
   localparam logic [SIZE_BITS-1:0] SZ_16 = 3'd4;

endpackage

/* design/lu_rot16.sv */
// One bit of every lane; selects must be one-hot, an all-zero select gives a zero output
`timescale 1ns/1ps

module lu_rot16 (
   input  logic [0:lu_pkg::ENDIAN_SEL_BITS-1] rot_sel1,
   input  logic [0:lu_pkg::ROT_SEL_BITS-1]    rot_sel2,
   input  logic [0:lu_pkg::ROT_SEL_BITS-1]    rot_sel3,
   input  logic [0:lu_pkg::QW_BYTES-1]        rot_data,
   output logic [0:lu_pkg::QW_BYTES-1]        data_rot
);

   localparam int LANES  = lu_pkg::QW_BYTES;
   localparam int COARSE = LANES / 4;

   logic [0:LANES-1] mxbele;
   logic [0:LANES-1] mx1;
   logic [0:LANES-1] mx2;

   for (genvar i = 0; i < LANES; i++) begin : g_lane
      // Endian stage, lane i straight or mirrored
      assign mxbele[i] = (rot_sel1[0] & rot_data[i]) |
                         (rot_sel1[1] & rot_data[LANES-1-i]);

      // Coarse rotate by 0, 4, 8 or 12 lanes
      assign mx1[i] = (rot_sel2[0] & mxbele[i]) |
                      (rot_sel2[1] & mxbele[(i + COARSE) % LANES]) |
                      (rot_sel2[2] & mxbele[(i + 2*COARSE) % LANES]) |
                      (rot_sel2[3] & mxbele[(i + 3*COARSE) % LANES]);

      // Fine rotate by 0 to 3 lanes
      assign mx2[i] = (rot_sel3[0] & mx1[i]) |
                      (rot_sel3[1] & mx1[(i + 1) % LANES]) |
                      (rot_sel3[2] & mx1[(i + 2) % LANES]) |
                      (rot_sel3[3] & mx1[(i + 3) % LANES]);
   end

   assign data_rot = mx2;

endmodule

/* design/lu_rot_decode.sv */
// First pipe stage; offsets are not range checked, so loads past byte 15 wrap around the quadword
`timescale 1ns/1ps

module lu_rot_decode #(
   parameter int BYTE_BITS = 8
) (
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic                                        ld_valid,
   input  logic [lu_pkg::ROT_BITS-1:0]                 ld_offset,
   input  logic [lu_pkg::SIZE_BITS-1:0]                ld_size,
   input  logic                                        ld_byte_rev,
   input  logic [0:lu_pkg::QW_BYTES*BYTE_BITS-1]       ld_data,
   output logic                                        s1_valid,
   output logic [0:lu_pkg::QW_BYTES*BYTE_BITS-1]       s1_data,
   output logic [0:lu_pkg::ENDIAN_SEL_BITS-1]          rot_sel1,
   output logic [0:lu_pkg::ROT_SEL_BITS-1]             rot_sel2,
   output logic [0:lu_pkg::ROT_SEL_BITS-1]             rot_sel3,
   output logic [0:lu_pkg::QW_BYTES-1]                 s1_mask
);

   // One bit wider than an offset so that a 16 byte size fits
   localparam int AMT_W = lu_pkg::ROT_BITS + 1;

   logic [AMT_W-1:0]                      size_bytes;
   logic [lu_pkg::ROT_BITS-1:0]           rot_amt;
   logic [0:lu_pkg::ENDIAN_SEL_BITS-1]    sel1_d;
   logic [0:lu_pkg::ROT_SEL_BITS-1]       sel2_d;
   logic [0:lu_pkg::ROT_SEL_BITS-1]       sel3_d;
   logic [0:lu_pkg::QW_BYTES-1]           mask_d;

   always_comb begin
      case (ld_size)
         lu_pkg::SZ_1:  size_bytes = AMT_W'(1);
         lu_pkg::SZ_2:  size_bytes = AMT_W'(2);
         lu_pkg::SZ_4:  size_bytes = AMT_W'(4);
         lu_pkg::SZ_8:  size_bytes = AMT_W'(8);
         default:       size_bytes = AMT_W'(16);
      endcase
   end

   // A straight load rotates its last byte into lane 15; a reversed load
   // mirrors first, which puts the first byte at 15 - offset
   always_comb begin
      if (ld_byte_rev) begin
         rot_amt = '0 - ld_offset;
      end else begin
         rot_amt = ld_offset + size_bytes[lu_pkg::ROT_BITS-1:0];
      end
   end

   assign sel1_d = {~ld_byte_rev, ld_byte_rev};

   // Upper two bits of the amount pick the coarse step of four lanes
   always_comb begin
      for (int k = 0; k < lu_pkg::ROT_SEL_BITS; k++) begin
         sel2_d[k] = (rot_amt[lu_pkg::ROT_BITS-1:2] == 2'(k));
         sel3_d[k] = (rot_amt[1:0] == 2'(k));
      end
   end

   // Keep only the low s lanes of the result
   always_comb begin
      for (int i = 0; i < lu_pkg::QW_BYTES; i++) begin
         mask_d[i] = (i >= lu_pkg::QW_BYTES - int'(size_bytes));
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
         s1_data  <= '0;
         rot_sel1 <= '0;
         rot_sel2 <= '0;
         rot_sel3 <= '0;
         s1_mask  <= '0;
      end else begin
         s1_valid <= ld_valid;
         s1_data  <= ld_data;
         rot_sel1 <= sel1_d;
         rot_sel2 <= sel2_d;
         rot_sel3 <= sel3_d;
         s1_mask  <= mask_d;
      end
   end

endmodule

/* design/lu_align_stage.sv */
// Second pipe stage; selects and mask must come from the same load as s1_data
`timescale 1ns/1ps

module lu_align_stage #(
   parameter int BYTE_BITS = 8
) (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   s1_valid,
   input  logic [0:lu_pkg::QW_BYTES*BYTE_BITS-1]  s1_data,
   input  logic [0:lu_pkg::ENDIAN_SEL_BITS-1]     rot_sel1,
   input  logic [0:lu_pkg::ROT_SEL_BITS-1]        rot_sel2,
   input  logic [0:lu_pkg::ROT_SEL_BITS-1]        rot_sel3,
   input  logic [0:lu_pkg::QW_BYTES-1]            s1_mask,
   output logic                                   rot_valid,
   output logic [0:lu_pkg::QW_BYTES*BYTE_BITS-1]  rot_data
);

   localparam int LANES = lu_pkg::QW_BYTES;

   logic [0:LANES-1]           slice_in  [BYTE_BITS];
   logic [0:LANES-1]           slice_out [BYTE_BITS];
   logic [0:LANES*BYTE_BITS-1] aligned;

   // Gather bit b of every lane into slice b
   always_comb begin
      for (int b = 0; b < BYTE_BITS; b++) begin
         for (int i = 0; i < LANES; i++) begin
            slice_in[b][i] = s1_data[i*BYTE_BITS + b];
         end
      end
   end

   for (genvar b = 0; b < BYTE_BITS; b++) begin : g_slice
      lu_rot16 u_rot16 (
         .rot_sel1 (rot_sel1),
         .rot_sel2 (rot_sel2),
         .rot_sel3 (rot_sel3),
         .rot_data (slice_in[b]),
         .data_rot (slice_out[b])
      );
   end

   // Back into lanes, with the lanes above the load size cleared
   always_comb begin
      for (int b = 0; b < BYTE_BITS; b++) begin
         for (int i = 0; i < LANES; i++) begin
            aligned[i*BYTE_BITS + b] = slice_out[b][i] & s1_mask[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rot_valid <= 1'b0;
         rot_data  <= '0;
      end else begin
         rot_valid <= s1_valid;
         rot_data  <= aligned;
      end
   end

endmodule

/* design/lu_align_top.sv */
// Load alignment path, two cycle fixed latency, one load per cycle and no back-pressure
`timescale 1ns/1ps

module lu_align_top #(
   parameter int BYTE_BITS = 8
) (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   ld_valid,
   input  logic [lu_pkg::ROT_BITS-1:0]            ld_offset,
   input  logic [lu_pkg::SIZE_BITS-1:0]           ld_size,
   input  logic                                   ld_byte_rev,
   input  logic [0:lu_pkg::QW_BYTES*BYTE_BITS-1]  ld_data,
   output logic                                   rot_valid,
   output logic [0:lu_pkg::QW_BYTES*BYTE_BITS-1]  rot_data
);

   logic                                  s1_valid;
   logic [0:lu_pkg::QW_BYTES*BYTE_BITS-1] s1_data;
   logic [0:lu_pkg::ENDIAN_SEL_BITS-1]    rot_sel1;
   logic [0:lu_pkg::ROT_SEL_BITS-1]       rot_sel2;
   logic [0:lu_pkg::ROT_SEL_BITS-1]       rot_sel3;
   logic [0:lu_pkg::QW_BYTES-1]           s1_mask;

   lu_rot_decode #(
      .BYTE_BITS (BYTE_BITS)
   ) u_decode (
      .clk         (clk),
      .reset       (reset),
      .ld_valid    (ld_valid),
      .ld_offset   (ld_offset),
      .ld_size     (ld_size),
      .ld_byte_rev (ld_byte_rev),
      .ld_data     (ld_data),
      .s1_valid    (s1_valid),
      .s1_data     (s1_data),
      .rot_sel1    (rot_sel1),
      .rot_sel2    (rot_sel2),
      .rot_sel3    (rot_sel3),
      .s1_mask     (s1_mask)
   );

   lu_align_stage #(
      .BYTE_BITS (BYTE_BITS)
   ) u_align (
      .clk       (clk),
      .reset     (reset),
      .s1_valid  (s1_valid),
      .s1_data   (s1_data),
      .rot_sel1  (rot_sel1),
      .rot_sel2  (rot_sel2),
      .rot_sel3  (rot_sel3),
      .s1_mask   (s1_mask),
      .rot_valid (rot_valid),
      .rot_data  (rot_data)
   );

endmodule

/* include/lu_align_ref.svh */
// Reference model for 8-bit lanes only; lu_pkg must be compiled before the file including this
`ifndef LU_ALIGN_REF_SVH
`define LU_ALIGN_REF_SVH

// Mirror if reversed, rotate left by r lanes, then clear lanes above the load size
function automatic logic [0:lu_pkg::QW_BYTES*8-1] lu_ref_align(
   input logic [0:lu_pkg::QW_BYTES*8-1] data,
   input logic [lu_pkg::ROT_BITS-1:0]   offset,
   input logic [lu_pkg::SIZE_BITS-1:0]  size,
   input logic                          rev
);
   logic [0:lu_pkg::QW_BYTES*8-1] b;
   logic [0:lu_pkg::QW_BYTES*8-1] res;
   int n;
   int s;
   int r;
   n = lu_pkg::QW_BYTES;
   s = (size >= lu_pkg::SZ_16) ? n : (1 << size);
   for (int i = 0; i < n; i++) begin
      b[i*8 +: 8] = rev ? data[(n-1-i)*8 +: 8] : data[i*8 +: 8];
   end
   r = rev ? (n - int'(offset)) % n : (int'(offset) + s) % n;
   for (int i = 0; i < n; i++) begin
      res[i*8 +: 8] = (i < n - s) ? 8'h00 : b[((i + r) % n)*8 +: 8];
   end
   return res;
endfunction

// One step of a 32-bit xorshift generator
function automatic logic [31:0] lu_xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

// Four chained steps from the given state fill one quadword
function automatic logic [0:lu_pkg::QW_BYTES*8-1] lu_rand_qw(input logic [31:0] state);
   logic [0:lu_pkg::QW_BYTES*8-1] w;
   logic [31:0] x;
   x = state;
   for (int k = 0; k < lu_pkg::QW_BYTES / 4; k++) begin
      x = lu_xorshift32(x);
      w[k*32 +: 32] = x;
   end
   return w;
endfunction

`endif

/* verification/lu_align_tb.sv */
// Checks 8-bit lanes only, the width the reference model covers; each test runs its table then drains
`timescale 1ns/1ps

module lu_align_tb;

   localparam int BYTE_BITS = 8;
   localparam int QW_W      = lu_pkg::QW_BYTES * BYTE_BITS;
   localparam int ROT_W     = lu_pkg::ROT_BITS;
   localparam int SIZE_W    = lu_pkg::SIZE_BITS;
   localparam int LATENCY   = 2;
   localparam int DRAIN_MAX = 8;
   localparam int DATA_PAT  = 0;
   localparam int DATA_RAND = 1;

   `include "lu_align_ref.svh"

   logic              clk;
   logic              reset;
   logic              ld_valid;
   logic [ROT_W-1:0]  ld_offset;
   logic [SIZE_W-1:0] ld_size;
   logic              ld_byte_rev;
   logic [0:QW_W-1]   ld_data;
   logic              rot_valid;
   logic [0:QW_W-1]   rot_data;

   // Vector table, one row per cycle, with the expected result of each row
   logic              tab_valid  [$];
   logic [ROT_W-1:0]  tab_offset [$];
   logic [SIZE_W-1:0] tab_size   [$];
   logic              tab_rev    [$];
   logic [0:QW_W-1]   tab_data   [$];
   logic [0:QW_W-1]   tab_want   [$];

   // Results in flight and the cycle on which each must show up
   logic [0:QW_W-1]   pend_data  [$];
   int                pend_due   [$];

   logic [31:0]       rng;
   int                cycle;
   int                checks;
   int                errors;
   int                test_checks;
   int                test_errors;
   bit                timed_out;

   lu_align_top #(
      .BYTE_BITS (BYTE_BITS)
   ) u_dut (
      .clk         (clk),
      .reset       (reset),
      .ld_valid    (ld_valid),
      .ld_offset   (ld_offset),
      .ld_size     (ld_size),
      .ld_byte_rev (ld_byte_rev),
      .ld_data     (ld_data),
      .rot_valid   (rot_valid),
      .rot_data    (rot_data)
   );

   always #50 clk = ~clk;

   task automatic check_valid(input logic got, input logic want);
      checks++;
      test_checks++;
      if (got !== want) begin
         errors++;
         test_errors++;
         $display("Fail t=%0t rot_valid got %b expected %b", $time, got, want);
      end
   endtask

   task automatic check_data(input logic [0:QW_W-1] got, input logic [0:QW_W-1] want);
      checks++;
      test_checks++;
      if (got !== want) begin
         errors++;
         test_errors++;
         $display("Fail t=%0t rot_data got %h expected %h", $time, got, want);
      end
   endtask

   // Byte i holds A0 plus i, so every lane is distinct and nonzero
   function automatic logic [0:QW_W-1] pattern_qw();
      logic [0:QW_W-1] w;
      for (int i = 0; i < lu_pkg::QW_BYTES; i++) begin
         w[i*BYTE_BITS +: BYTE_BITS] = BYTE_BITS'(8'hA0 + i);
      end
      return w;
   endfunction

   function automatic logic [0:QW_W-1] pick_data(input int sel);
      if (sel == DATA_RAND) begin
         rng = lu_xorshift32(rng);
         return lu_rand_qw(rng);
      end
      return pattern_qw();
   endfunction

   // The expected value uses ref_size, which lets a test state what a size code should mean
   task automatic add_row(input logic valid, input int off, input int size, input int ref_size,
                          input logic rev, input int sel);
      logic [0:QW_W-1] d;
      d = pick_data(sel);
      tab_valid.push_back(valid);
      tab_offset.push_back(ROT_W'(off));
      tab_size.push_back(SIZE_W'(size));
      tab_rev.push_back(rev);
      tab_data.push_back(d);
      if (valid) begin
         tab_want.push_back(lu_ref_align(d, ROT_W'(off), SIZE_W'(ref_size), rev));
      end else begin
         tab_want.push_back('0);
      end
   endtask

   task automatic clear_table();
      tab_valid.delete();
      tab_offset.delete();
      tab_size.delete();
      tab_rev.delete();
      tab_data.delete();
      tab_want.delete();
   endtask

   task automatic check_outputs();
      logic due;
      due = 1'b0;
      if (pend_due.size() > 0) begin
         due = (pend_due[0] == cycle);
      end
      check_valid(rot_valid, due);
      if (due) begin
         check_data(rot_data, pend_data.pop_front());
         void'(pend_due.pop_front());
      end
   endtask

   // Outputs are sampled before the new inputs go out on the same falling edge
   task automatic step(input logic valid, input logic [ROT_W-1:0] off,
                       input logic [SIZE_W-1:0] size, input logic rev,
                       input logic [0:QW_W-1] data, input logic [0:QW_W-1] want);
      @(negedge clk);
      cycle++;
      check_outputs();
      ld_valid    = valid;
      ld_offset   = off;
      ld_size     = size;
      ld_byte_rev = rev;
      ld_data     = data;
      if (valid) begin
         pend_data.push_back(want);
         pend_due.push_back(cycle + LATENCY);
      end
   endtask

   task automatic idle_step();
      step(1'b0, '0, '0, 1'b0, '0, '0);
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (pend_due.size() > 0 && waited < DRAIN_MAX) begin
         idle_step();
         waited++;
      end
      if (pend_due.size() > 0) begin
         $display("Timeout: %0d loads gave no result from the DUT", pend_due.size());
         timed_out = 1'b1;
      end
   endtask

   task automatic run_table(input int num, input string name);
      test_checks = 0;
      test_errors = 0;
      for (int k = 0; k < tab_valid.size(); k++) begin
         step(tab_valid[k], tab_offset[k], tab_size[k], tab_rev[k], tab_data[k], tab_want[k]);
      end
      drain();
      // One more idle cycle catches a stray rot_valid pulse
      idle_step();
      $display("Test %0d %s: %0d checks, %0d errors", num, name, test_checks, test_errors);
   endtask

   task automatic test_reset_idle();
      test_checks = 0;
      test_errors = 0;
      check_valid(rot_valid, 1'b0);
      check_data(rot_data, '0);
      for (int k = 0; k < 6; k++) begin
         idle_step();
      end
      $display("Test 1 reset and idle: %0d checks, %0d errors", test_checks, test_errors);
   endtask

   task automatic test_aligned();
      clear_table();
      for (int sz = 0; sz <= 4; sz++) begin
         for (int off = 0; off < lu_pkg::QW_BYTES; off += (1 << sz)) begin
            add_row(1'b1, off, sz, sz, 1'b0, DATA_PAT);
         end
      end
      run_table(2, "aligned loads");
   endtask

   task automatic test_reversed();
      clear_table();
      for (int sz = 1; sz <= 4; sz++) begin
         for (int off = 0; off < lu_pkg::QW_BYTES; off += (1 << sz)) begin
            add_row(1'b1, off, sz, sz, 1'b1, DATA_PAT);
         end
      end
      run_table(3, "byte-reversed loads");
   endtask

   // Every offset with every size reaches all coarse and fine rotate pairs, wrapped loads too
   task automatic test_unaligned();
      clear_table();
      for (int rev = 0; rev < 2; rev++) begin
         for (int sz = 0; sz <= 4; sz++) begin
            for (int off = 0; off < lu_pkg::QW_BYTES; off++) begin
               add_row(1'b1, off, sz, sz, rev[0], DATA_RAND);
            end
         end
      end
      run_table(4, "unaligned and wrapped loads");
   endtask

   task automatic test_back_to_back();
      int   off;
      int   size;
      logic rev;
      clear_table();
      for (int k = 0; k < 48; k++) begin
         if (k % 6 == 5 || k == 20) begin
            add_row(1'b0, 0, 0, 0, 1'b0, DATA_PAT);
         end else begin
            rng  = lu_xorshift32(rng);
            off  = int'(rng[3:0]);
            size = int'(rng[6:4]);
            rev  = rng[7];
            add_row(1'b1, off, size, size, rev, DATA_RAND);
         end
      end
      run_table(5, "back-to-back random loads");
   endtask

   task automatic test_large_codes();
      clear_table();
      for (int code = 5; code <= 7; code++) begin
         for (int rev = 0; rev < 2; rev++) begin
            add_row(1'b1, 0, code, int'(lu_pkg::SZ_16), rev[0], DATA_PAT);
            add_row(1'b1, 3, code, int'(lu_pkg::SZ_16), rev[0], DATA_RAND);
            add_row(1'b1, 9, code, int'(lu_pkg::SZ_16), rev[0], DATA_RAND);
            add_row(1'b1, 15, code, int'(lu_pkg::SZ_16), rev[0], DATA_PAT);
         end
      end
      run_table(6, "size codes 5 to 7");
   endtask

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      ld_valid    = 1'b0;
      ld_offset   = '0;
      ld_size     = '0;
      ld_byte_rev = 1'b0;
      ld_data     = '0;
      rng         = 32'd31;
      cycle       = 0;
      checks      = 0;
      errors      = 0;
      timed_out   = 1'b0;

      repeat (2) @(negedge clk);
      reset = 1'b0;

      test_reset_idle();
      if (!timed_out) test_aligned();
      if (!timed_out) test_reversed();
      if (!timed_out) test_unaligned();
      if (!timed_out) test_back_to_back();
      if (!timed_out) test_large_codes();

      $display("Total %0d checks, %0d errors", checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* files.f */
+incdir+include
design/lu_pkg.sv
design/lu_rot16.sv
design/lu_rot_decode.sv
design/lu_align_stage.sv
design/lu_align_top.sv
verification/lu_align_tb.sv

/* Makefile */
# Verilator build and run of the load alignment testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -sv --timescale 1ns/1ps --top-module lu_align_tb \
		-f files.f -Mdir obj_dir -o lu_align_sim

run: compile
	./obj_dir/lu_align_sim | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
